// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_if_stage_top
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# pass only if the log holds the pass line
run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== hw/fetch_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_ctrl (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   start,      // one-cycle pulse
    input  wire logic                   stall,      // hold everything
    input  wire fetch_pkg::branch_req_t branch,
    input  wire logic                   last_pair,  // current pair is the highest one
    output logic                        advance,    // normal pair fetch
    output logic                        redirect,   // taken branch fetch
    output logic                        run_en,
    output logic                        done
);
    import fetch_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        take;  // both branch levels high

    assign take = branch.is_branch & branch.taken;

    // next state and fetch strobes
    always_comb begin
        state_d  = state_q;
        advance  = 1'b0;
        redirect = 1'b0;
        unique case (state_q)
            LOAD: begin
                if (start) state_d = RUN;  // writes may still arrive later
            end
            RUN: begin
                if (!stall) begin  // stall wins and drops any branch
                    if (take) begin
                        redirect = 1'b1;
                    end else begin
                        advance = 1'b1;
                        if (last_pair) state_d = DONE;  // final pair goes out this edge
                    end
                end
            end
            DONE: begin
                if (!stall && take) begin  // restart at the target
                    redirect = 1'b1;
                    state_d  = RUN;
                end
            end
            default: state_d = LOAD;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) state_q <= LOAD;
        else     state_q <= state_d;
    end

    assign run_en = (state_q == RUN);
    assign done   = (state_q == DONE);

    // one kind of fetch per cycle
    a_fetch_excl: assert property (@(posedge clk) disable iff (rst)
        !(advance && redirect));

    // fetch only in run or on a branch out of done and never under stall
    a_fetch_legal: assert property (@(posedge clk) disable iff (rst)
        (advance || redirect) |->
            (!stall && (state_q == RUN || (redirect && state_q == DONE))));

endmodule

`default_nettype wire

// ==== hw/fetch_latch.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_latch (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            advance,
    input  wire logic            redirect,
    input  wire logic            run_en,      // control is in run
    input  wire logic            odd_target,
    input  wire fetch_pkg::pc_t  pair_addr,
    input  wire mem_pkg::instr_t rd_data0,
    input  wire mem_pkg::instr_t rd_data1,
    output fetch_pkg::fetch_bundle_t bundle
);
    import mem_pkg::*;
    import fetch_pkg::*;

    fetch_bundle_t bundle_q;
    logic          ins_nop;  // odd branch target, first slot is skipped

    assign ins_nop = redirect & odd_target;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bundle_q <= '0;
        end else if (advance || redirect) begin
            bundle_q.valid    <= 1'b1;
            bundle_q.find_nop <= ins_nop;  // tells decode which slot is filler
            bundle_q.pc       <= pair_addr;
            bundle_q.slot0    <= ins_nop ? instr_t'('0) : rd_data0;
            bundle_q.slot1    <= rd_data1;  // word at the target when odd
        end else if (!run_en) begin
            bundle_q.valid    <= 1'b0;  // load or done, nothing live
            bundle_q.find_nop <= 1'b0;
        end
        // otherwise stall, the whole bundle holds
    end

    assign bundle = bundle_q;

    // the flagged slot really carries the nop
    a_nop_slot0: assert property (@(posedge clk) disable iff (rst)
        bundle_q.find_nop |-> (bundle_q.slot0 == '0));

endmodule

`default_nettype wire

// ==== hw/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // word address, upper bits above ADDR_W stay zero
    typedef logic [15:0] pc_t;

    // branch information from outside, 18 bits
    typedef struct packed {
        logic is_branch;  // level
        logic taken;      // level
        pc_t  target;     // may be odd
    } branch_req_t;

    // one fetched pair as seen by decode, 82 bits
    typedef struct packed {
        logic            valid;     // pair is live
        logic            find_nop;  // slot0 was replaced by a nop
        pc_t             pc;        // aligned address of slot0
        mem_pkg::instr_t slot0;     // word at pc
        mem_pkg::instr_t slot1;     // word at pc + 1
    } fetch_bundle_t;

    // sequencing of the stage
    typedef enum logic [1:0] {
        LOAD = 2'd0,  // waiting for start, program being written
        RUN  = 2'd1,  // fetching a pair per cycle
        DONE = 2'd2   // last pair fetched, waiting for a branch
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hw/if_stage_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module if_stage_top #(
    parameter int ADDR_W = mem_pkg::DEF_ADDR_W
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire mem_pkg::load_req_t     load,
    input  wire logic                   start,
    input  wire logic                   stall,
    input  wire fetch_pkg::branch_req_t branch,
    output fetch_pkg::fetch_bundle_t    bundle,
    output logic                        done
);
    import mem_pkg::*;
    import fetch_pkg::*;

    localparam pc_t ADDR_MASK = pc_t'((1 << ADDR_W) - 1);

    logic   advance;
    logic   redirect;
    logic   run_en;
    logic   last_pair;
    logic   odd_target;
    pc_t    pc_q;
    pc_t    rd_addr0;
    pc_t    rd_addr1;
    pc_t    pair_addr;
    instr_t rd_data0;
    instr_t rd_data1;

    fetch_ctrl fetch_ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .stall     (stall),
        .branch    (branch),
        .last_pair (last_pair),
        .advance   (advance),
        .redirect  (redirect),
        .run_en    (run_en),
        .done      (done)
    );

    program_counter #(.ADDR_W(ADDR_W)) program_counter_i (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .redirect   (redirect),
        .target     (branch.target),
        .pc_q       (pc_q),
        .rd_addr0   (rd_addr0),
        .rd_addr1   (rd_addr1),
        .pair_addr  (pair_addr),
        .odd_target (odd_target),
        .last_pair  (last_pair)
    );

    instr_buffer #(.ADDR_W(ADDR_W)) instr_buffer_i (
        .clk      (clk),
        .load     (load),
        .rd_addr0 (rd_addr0),
        .rd_addr1 (rd_addr1),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1)
    );

    fetch_latch fetch_latch_i (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .redirect   (redirect),
        .run_en     (run_en),
        .odd_target (odd_target),
        .pair_addr  (pair_addr),
        .rd_data0   (rd_data0),
        .rd_data1   (rd_data1),
        .bundle     (bundle)
    );

    // counter runs one pair ahead of the bundle after every fetch
    a_pc_ahead: assert property (@(posedge clk) disable iff (rst)
        (advance || redirect) |=> (pc_q == ((bundle.pc + pc_t'(2)) & ADDR_MASK)));

endmodule

`default_nettype wire

// ==== hw/instr_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_buffer #(
    parameter int ADDR_W = 10
) (
    input  wire logic                clk,
    input  wire mem_pkg::load_req_t  load,      // write port
    input  wire fetch_pkg::pc_t      rd_addr0,
    input  wire fetch_pkg::pc_t      rd_addr1,
    output mem_pkg::instr_t          rd_data0,
    output mem_pkg::instr_t          rd_data1
);
    import mem_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;  // words held

    instr_t mem [DEPTH];  // contents come from the load port only

    // synchronous write, one word per strobe
    always_ff @(posedge clk) begin
        if (load.en) begin
            mem[load.addr[ADDR_W-1:0]] <= load.data;
        end
    end

    // two asynchronous reads for the pair
    assign rd_data0 = mem[rd_addr0[ADDR_W-1:0]];
    assign rd_data1 = mem[rd_addr1[ADDR_W-1:0]];

endmodule

`default_nettype wire

// ==== hw/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // buffer geometry
    localparam int INSTR_W    = 32;  // bits per instruction word
    localparam int DEF_ADDR_W = 10;  // 1024 words unless the top level overrides

    // one instruction word, all zero is the nop
    typedef logic [INSTR_W-1:0] instr_t;

    // write port of the instruction buffer, 49 bits
    typedef struct packed {
        logic        en;    // one-cycle write strobe
        logic [15:0] addr;  // word address, low ADDR_W bits used
        instr_t      data;  // word to store
    } load_req_t;

endpackage

`default_nettype wire

// ==== hw/program_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module program_counter #(
    parameter int ADDR_W = 10
) (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           advance,
    input  wire logic           redirect,
    input  wire fetch_pkg::pc_t target,      // raw branch target
    output fetch_pkg::pc_t      pc_q,        // next even address to fetch
    output fetch_pkg::pc_t      rd_addr0,
    output fetch_pkg::pc_t      rd_addr1,
    output fetch_pkg::pc_t      pair_addr,   // aligned address being read
    output logic                odd_target,
    output logic                last_pair
);
    import fetch_pkg::*;

    localparam pc_t ADDR_MASK = pc_t'((1 << ADDR_W) - 1);  // valid address bits
    localparam pc_t LAST_PAIR = ADDR_MASK & ~pc_t'(1);      // highest even address

    pc_t aligned_target;
    pc_t pc_d;

    assign aligned_target = target & ADDR_MASK & ~pc_t'(1);  // drop the odd bit
    assign odd_target     = target[0];

    // read the target pair on a redirect, else the running address
    assign pair_addr = redirect ? aligned_target : pc_q;
    assign rd_addr0  = pair_addr;
    assign rd_addr1  = pair_addr + pc_t'(1);  // even base, no carry out of the mask

    // only looked at by control on a normal advance, where pc_q is the read address
    assign last_pair = (pc_q == LAST_PAIR);

    assign pc_d = (pair_addr + pc_t'(2)) & ADDR_MASK;  // wraps inside the buffer

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q <= '0;
        end else if (advance || redirect) begin
            pc_q <= pc_d;  // holds under stall and outside run
        end
    end

    // fetch address stays pair aligned and inside the buffer
    a_pc_even: assert property (@(posedge clk) disable iff (rst)
        (pc_q[0] == 1'b0) && ((pc_q & ~ADDR_MASK) == '0));

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verif
hw/mem_pkg.sv
hw/fetch_pkg.sv
hw/fetch_ctrl.sv
hw/program_counter.sv
hw/instr_buffer.sv
hw/fetch_latch.sv
hw/if_stage_top.sv
verif/tb_if_stage_top.sv

// ==== verif/if_model.svh ====
`ifndef IF_MODEL_SVH
`define IF_MODEL_SVH

// reference model of the fetch stage, stepped once per clock edge
localparam int  MODEL_DEPTH = 1 << TB_ADDR_W;
localparam pc_t MODEL_MASK  = pc_t'(MODEL_DEPTH - 1);  // valid address bits

instr_t        model_mem [MODEL_DEPTH];  // copy of the buffer
ctrl_state_t   model_state;
pc_t           model_pc;                 // next even address
fetch_bundle_t exp_bundle;               // bundle expected after the edge
logic          exp_done;
int            odd_redirects;            // odd targets taken, for the test log

function automatic void reset_model();
    model_state   = LOAD;
    model_pc      = '0;
    exp_bundle    = '0;
    exp_done      = 1'b0;
    odd_redirects = 0;
endfunction

// pair at base goes out, counter moves one pair on
function automatic void fetch_pair(input pc_t base, input logic nop_first);
    pc_t upper;
    upper = (base + pc_t'(1)) & MODEL_MASK;
    exp_bundle.valid    = 1'b1;
    exp_bundle.find_nop = nop_first;
    exp_bundle.pc       = base;
    exp_bundle.slot0    = nop_first ? instr_t'(0) : model_mem[base[TB_ADDR_W-1:0]];
    exp_bundle.slot1    = model_mem[upper[TB_ADDR_W-1:0]];
    model_pc            = (base + pc_t'(2)) & MODEL_MASK;
endfunction

// odd target skips the first word of its pair
function automatic void redirect_to(input pc_t target);
    if (target[0]) odd_redirects++;
    fetch_pair(target & MODEL_MASK & ~pc_t'(1), target[0]);
endfunction

// inputs seen at the coming edge, reads before the write
function automatic void predict_cycle(input load_req_t ld, input logic st, input logic hold,
                                      input branch_req_t br);
    logic take;
    take = br.is_branch && br.taken;
    case (model_state)
        LOAD: begin
            exp_bundle.valid    = 1'b0;
            exp_bundle.find_nop = 1'b0;
            if (st) model_state = RUN;
        end
        RUN: begin
            if (!hold && take) begin
                redirect_to(br.target);
            end else if (!hold) begin
                if (model_pc == MODEL_MASK - pc_t'(1)) model_state = DONE;  // top pair
                fetch_pair(model_pc, 1'b0);
            end
        end
        default: begin  // done
            if (!hold && take) begin
                model_state = RUN;
                redirect_to(br.target);
            end else begin
                exp_bundle.valid    = 1'b0;
                exp_bundle.find_nop = 1'b0;
            end
        end
    endcase
    if (ld.en) model_mem[ld.addr[TB_ADDR_W-1:0]] = ld.data;
    exp_done = (model_state == DONE);
endfunction

`endif

// ==== verif/tb_if_stage_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_if_stage_top;
    import mem_pkg::*;
    import fetch_pkg::*;

    localparam int TB_ADDR_W  = 6;     // 64 words for short runs
    localparam int MAX_CYCLES = 4000;  // per wait loop

    logic          clk;
    logic          rst;
    load_req_t     load;
    logic          start;
    logic          stall;
    branch_req_t   branch;
    fetch_bundle_t bundle;
    logic          done;

    integer seed;
    int     errors;
    int     checks;
    int     test_start_errors;

    `include "if_model.svh"

    if_stage_top #(.ADDR_W(TB_ADDR_W)) if_stage_top_i (
        .clk    (clk),
        .rst    (rst),
        .load   (load),
        .start  (start),
        .stall  (stall),
        .branch (branch),
        .bundle (bundle),
        .done   (done)
    );

    always #2 clk = ~clk;  // 4 ns period

    task automatic compare_outputs();
        checks++;
        assert (bundle.valid == exp_bundle.valid) else begin
            $display("Error at %0t: bundle.valid = %h, expected %h", $time, bundle.valid,
                     exp_bundle.valid);
            errors++;
        end
        assert (bundle.find_nop == exp_bundle.find_nop) else begin
            $display("Error at %0t: bundle.find_nop = %h, expected %h", $time, bundle.find_nop,
                     exp_bundle.find_nop);
            errors++;
        end
        if (exp_bundle.valid) begin  // contents only matter for a live pair
            assert (bundle.pc == exp_bundle.pc) else begin
                $display("Error at %0t: bundle.pc = %h, expected %h", $time, bundle.pc,
                         exp_bundle.pc);
                errors++;
            end
            assert (bundle.slot0 == exp_bundle.slot0) else begin
                $display("Error at %0t: bundle.slot0 = %h, expected %h", $time, bundle.slot0,
                         exp_bundle.slot0);
                errors++;
            end
            assert (bundle.slot1 == exp_bundle.slot1) else begin
                $display("Error at %0t: bundle.slot1 = %h, expected %h", $time, bundle.slot1,
                         exp_bundle.slot1);
                errors++;
            end
        end
        assert (done == exp_done) else begin
            $display("Error at %0t: done = %h, expected %h", $time, done, exp_done);
            errors++;
        end
    endtask

    task automatic check_slots_zero();
        assert (bundle.slot0 == '0) else begin
            $display("Error at %0t: bundle.slot0 = %h, expected 0", $time, bundle.slot0);
            errors++;
        end
        assert (bundle.slot1 == '0) else begin
            $display("Error at %0t: bundle.slot1 = %h, expected 0", $time, bundle.slot1);
            errors++;
        end
    endtask

    // one clock edge with the inputs as driven now and a compare after it
    task automatic tick();
        logic held;
        held = stall && (model_state == RUN);
        predict_cycle(load, start, stall, branch);
        @(posedge clk);
        #0.5;  // registered outputs settled at the next drive point
        compare_outputs();
        if (held) begin  // whole bundle frozen, stale fields too
            assert (bundle == exp_bundle) else begin
                $display("Error at %0t: bundle = %h during stall, expected %h", $time, bundle,
                         exp_bundle);
                errors++;
            end
        end
    endtask

    // random stall runs and branch requests until done rises
    task automatic run_to_done(input bit use_stall, input bit use_branch);
        int n;
        int hold_left;
        n         = 0;
        hold_left = 0;
        while (!done && n < MAX_CYCLES) begin
            if (use_stall && hold_left == 0) begin
                stall     = (($random(seed) & 7) < 3);
                hold_left = 1 + ($random(seed) & 3);  // level kept for 1 to 4 cycles
            end
            if (hold_left > 0) hold_left--;
            if (use_branch) begin
                branch.is_branch = (($random(seed) & 3) == 0);
                branch.taken     = 1'($random(seed) & 1);
                branch.target    = pc_t'($random(seed) & MODEL_MASK);  // even and odd
            end
            tick();
            n++;
        end
        stall  = 1'b0;
        branch = '0;
        if (!done) begin
            $display("timeout: done did not rise within %0d cycles", MAX_CYCLES);
            errors++;
        end else begin
            tick();  // valid has to drop here
        end
    endtask

    task automatic restart_at(input pc_t target);
        branch.is_branch = 1'b1;
        branch.taken     = 1'b1;
        branch.target    = target;
        stall            = 1'b0;
        tick();
        branch = '0;
    endtask

    task automatic report_test(input int num, input string name);
        if (errors == test_start_errors) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    initial begin
        pc_t tgt;
        clk               = 1'b0;
        rst               = 1'b1;
        load              = '0;
        start             = 1'b0;
        stall             = 1'b0;
        branch            = '0;
        seed              = 87;
        errors            = 0;
        checks            = 0;
        test_start_errors = 0;
        reset_model();
        repeat (4) @(posedge clk);
        #0.5;
        rst = 1'b0;

        // reset values and a fill of every word while in load
        compare_outputs();
        check_slots_zero();
        for (int i = 0; i < MODEL_DEPTH; i++) begin
            load.en   = 1'b1;
            load.addr = 16'(i);
            load.data = $random(seed);
            tick();
        end
        load = '0;
        tick();
        check_slots_zero();
        report_test(1, "reset and load");

        start = 1'b1;  // single pulse
        tick();
        start = 1'b0;
        run_to_done(1'b0, 1'b0);
        report_test(2, "straight run to done");

        restart_at('0);
        run_to_done(1'b1, 1'b0);
        report_test(3, "random stalls");

        restart_at('0);
        run_to_done(1'b1, 1'b1);
        $display("  odd targets taken so far: %0d", odd_redirects);
        report_test(4, "random branches");

        for (int k = 0; k < 4; k++) begin
            tgt = pc_t'($random(seed)) & MODEL_MASK;
            if (k[0]) tgt[0] = 1'b1;  // alternate odd targets
            branch.is_branch = 1'b1;
            branch.taken     = 1'b1;
            branch.target    = tgt;
            stall            = 1'b1;  // dropped while the stage stays done
            tick();
            restart_at(tgt);
            run_to_done(1'b0, 1'b0);
        end
        report_test(5, "restart from done");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
